/* files.f */
icache_pkg.sv
scr_ram_1p.sv
scr_key_ctrl.sv
icache_lookup.sv
icache_fill.sv
icache_output.sv
icache_top.sv
icache_tb.sv

/* icache_fill.sv */
/*
 * Line fill stage
 * Fetches a four-beat line or a single bypass word over the instruction bus
 */
`timescale 1ns/100ps
`default_nettype none

module icache_fill import icache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  lookup_op_e             lookup_op_i,
  input  logic [ADDR_W-1:0]      lookup_addr_i,
  output logic                   instr_req_o,
  output logic [ADDR_W-1:0]      instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [WORD_W-1:0]      instr_rdata_i,
  input  logic                   instr_err_i,
  output logic                   tag_write_o,
  output logic                   data_write_o,
  output logic [IC_INDEX_W-1:0]  wr_index_o,
  output logic [IC_TAG_SIZE-1:0] tag_wdata_o,
  output logic [IC_LINE_W-1:0]   data_wdata_o,
  output logic                   fill_line_valid_o,
  output logic                   fill_busy_o,
  output logic                   fill_done_o,
  output logic [WORD_W-1:0]      fill_rdata_o,
  output logic                   fill_err_o
);

  fill_state_e          state_q, state_d;
  logic [IC_BEAT_W-1:0] beat_q;
  logic                 bypass_q;
  logic                 err_q;
  logic [ADDR_W-1:0]    addr_q;
  logic [IC_LINE_W-1:0] line_q;
  logic [WORD_W-1:0]    word_q;
  logic                 start;
  logic                 last_beat;
  logic                 line_write;

  assign start     = (lookup_op_i == OP_MISS_FILL) || (lookup_op_i == OP_BYPASS);
  assign last_beat = bypass_q || (beat_q == IC_BEAT_W'(IC_LINE_BEATS - 1));

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      FILL_IDLE:  if (start) state_d = FILL_REQ;
      FILL_REQ:   if (instr_gnt_i) state_d = FILL_WAIT;
      FILL_WAIT: begin
        if (instr_rvalid_i) begin
          if (!last_beat)     state_d = FILL_REQ;
          else if (bypass_q)  state_d = FILL_RESP;
          else                state_d = FILL_WRITE;
        end
      end
      FILL_WRITE: state_d = FILL_IDLE;
      FILL_RESP:  state_d = FILL_IDLE;
      default:    state_d = FILL_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q  <= FILL_IDLE;
      beat_q   <= '0;
      bypass_q <= 1'b0;
      err_q    <= 1'b0;
    end else begin
      state_q <= state_d;
      if (state_q == FILL_IDLE && start) begin
        bypass_q <= (lookup_op_i == OP_BYPASS);
        err_q    <= 1'b0;
        // Line fills always start at beat 0
        beat_q   <= (lookup_op_i == OP_BYPASS) ?
                    lookup_addr_i[IC_INDEX_LSB-1:2] : '0;
      end else if (state_q == FILL_WAIT && instr_rvalid_i) begin
        err_q <= err_q | instr_err_i;
        if (!last_beat) begin
          beat_q <= beat_q + 1'b1;
        end
      end
    end
  end

  // Line buffer and returned word
  always_ff @(posedge clk) begin
    if (state_q == FILL_IDLE && start) begin
      addr_q <= lookup_addr_i;
    end
    if (state_q == FILL_WAIT && instr_rvalid_i) begin
      line_q[beat_q*WORD_W +: WORD_W] <= instr_rdata_i;
      if (beat_q == addr_q[IC_INDEX_LSB-1:2]) begin
        word_q <= instr_rdata_i;
      end
    end
  end

  assign instr_req_o  = (state_q == FILL_REQ);
  assign instr_addr_o = {addr_q[ADDR_W-1:IC_INDEX_LSB], beat_q, 2'b00};

  // Lines with a bus error are never written
  assign line_write        = (state_q == FILL_WRITE) && !err_q;
  assign tag_write_o       = line_write;
  assign data_write_o      = line_write;
  assign fill_line_valid_o = line_write;
  assign wr_index_o        = addr_q[IC_TAG_LSB-1:IC_INDEX_LSB];
  assign tag_wdata_o       = addr_q[ADDR_W-1:IC_TAG_LSB];
  assign data_wdata_o      = line_q;

  assign fill_busy_o  = (state_q != FILL_IDLE);
  assign fill_done_o  = (state_q == FILL_WRITE) || (state_q == FILL_RESP);
  assign fill_rdata_o = word_q;
  assign fill_err_o   = err_q;

  // Request and address hold until granted
  req_hold_a: assert property (@(posedge clk) disable iff (!rst_n)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

endmodule

`default_nettype wire

/* icache_lookup.sv */
/*
 * Cache lookup stage
 * Accepts fetches, reads tag and data RAM, then decides hit, miss or bypass
 */
`timescale 1ns/100ps
`default_nettype none

module icache_lookup import icache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic [ADDR_W-1:0]      addr_i,
  input  logic                   enable_i,
  input  logic                   inval_i,
  input  logic                   key_ok_i,
  input  logic                   fill_busy_i,
  input  logic                   fill_line_valid_i,
  input  logic [IC_INDEX_W-1:0]  fill_index_i,
  output logic                   tag_req_o,
  input  logic [IC_TAG_SIZE-1:0] tag_rdata_i,
  output logic                   data_req_o,
  input  logic [IC_LINE_W-1:0]   data_rdata_i,
  output lookup_op_e             lookup_op_o,
  output logic [ADDR_W-1:0]      lookup_addr_o,
  output logic [IC_LINE_W-1:0]   lookup_line_o,
  output logic                   busy_o
);

  logic                    accept;
  logic                    lookup_q;
  logic                    enable_q;
  logic [ADDR_W-1:0]       addr_q;
  logic [IC_NUM_LINES-1:0] valid_q;
  logic [IC_INDEX_W-1:0]   index;
  logic                    hit;

  assign busy_o = lookup_q | fill_busy_i | ~key_ok_i;
  assign accept = req_i & ~busy_o;

  // Both RAMs are read on the accepting edge
  assign tag_req_o  = accept;
  assign data_req_o = accept;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lookup_q <= 1'b0;
      enable_q <= 1'b0;
    end else begin
      lookup_q <= accept;
      if (accept) begin
        enable_q <= enable_i;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      addr_q <= addr_i;
    end
  end

  // Line valid bits, only trusted when written under the current key
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else if (inval_i) begin
      valid_q <= '0;
    end else if (fill_line_valid_i && key_ok_i) begin
      valid_q[fill_index_i] <= 1'b1;
    end
  end

  assign index = addr_q[IC_TAG_LSB-1:IC_INDEX_LSB];
  assign hit   = valid_q[index] && (tag_rdata_i == addr_q[ADDR_W-1:IC_TAG_LSB]);

  always_comb begin
    lookup_op_o = OP_NONE;
    if (lookup_q) begin
      if (!enable_q)  lookup_op_o = OP_BYPASS;
      else if (hit)   lookup_op_o = OP_HIT;
      else            lookup_op_o = OP_MISS_FILL;
    end
  end

  assign lookup_addr_o = addr_q;
  assign lookup_line_o = data_rdata_i;

  // The core waits for busy to drop before fetching
  no_req_when_busy_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !busy_o);

endmodule

`default_nettype wire

/* icache_output.sv */
/*
 * Response stage
 * Registers the fetched word, its address and error for the core
 */
`timescale 1ns/100ps
`default_nettype none

module icache_output import icache_pkg::*; (
  input  logic                 clk,
  input  logic                 rst_n,
  input  lookup_op_e           lookup_op_i,
  input  logic [ADDR_W-1:0]    lookup_addr_i,
  input  logic [IC_LINE_W-1:0] lookup_line_i,
  input  logic                 fill_done_i,
  input  logic [WORD_W-1:0]    fill_rdata_i,
  input  logic                 fill_err_i,
  output logic                 valid_o,
  output logic [WORD_W-1:0]    rdata_o,
  output logic [ADDR_W-1:0]    addr_o,
  output logic                 err_o
);

  logic                 hit;
  logic [IC_BEAT_W-1:0] beat;
  logic                 valid_q;
  logic [WORD_W-1:0]    rdata_q;
  logic [ADDR_W-1:0]    addr_q;
  logic                 err_q;

  assign hit  = (lookup_op_i == OP_HIT);
  assign beat = lookup_addr_i[IC_INDEX_LSB-1:2];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      valid_q <= 1'b0;
    end else begin
      valid_q <= hit | fill_done_i;
    end
  end

  always_ff @(posedge clk) begin
    if (hit) begin
      rdata_q <= lookup_line_i[beat*WORD_W +: WORD_W];
      addr_q  <= lookup_addr_i;
      err_q   <= 1'b0;
    end else if (fill_done_i) begin
      rdata_q <= fill_rdata_i;
      addr_q  <= lookup_addr_i;
      err_q   <= fill_err_i;
    end
  end

  assign valid_o = valid_q;
  assign rdata_o = rdata_q;
  assign addr_o  = addr_q;
  assign err_o   = err_q;

endmodule

`default_nettype wire

/* icache_pkg.sv */
/*
 * Instruction cache package
 * Cache geometry, scramble key widths and the FSM and decode enums
 */
`default_nettype none

package icache_pkg;

  // Bus and address geometry
  localparam int unsigned ADDR_W        = 32;
  localparam int unsigned WORD_W        = 32;
  localparam int unsigned IC_LINE_BEATS = 4;
  localparam int unsigned IC_NUM_LINES  = 16;
  localparam int unsigned IC_INDEX_W    = 4;
  localparam int unsigned IC_BEAT_W     = 2;
  localparam int unsigned IC_INDEX_LSB  = IC_BEAT_W + 2;
  localparam int unsigned IC_TAG_LSB    = IC_INDEX_LSB + IC_INDEX_W;
  localparam int unsigned IC_TAG_SIZE   = ADDR_W - IC_INDEX_W - IC_BEAT_W - 2;
  localparam int unsigned IC_LINE_W     = WORD_W * IC_LINE_BEATS;

  // Scrambling key material
  localparam int unsigned SCR_KEY_W   = 64;
  localparam int unsigned SCR_NONCE_W = 32;

  // Key and nonce in use straight out of reset
  localparam logic [SCR_KEY_W-1:0]   SCR_RST_KEY   = 64'hd1c3_5a7e_96b0_2f4d;
  localparam logic [SCR_NONCE_W-1:0] SCR_RST_NONCE = 32'hbbbe_effe;

  // Line fill FSM
  typedef enum logic [2:0] {
    FILL_IDLE,
    FILL_REQ,
    FILL_WAIT,
    FILL_WRITE,
    FILL_RESP
  } fill_state_e;

  // Key controller FSM
  typedef enum logic [1:0] {
    KEY_VALID,
    KEY_INVALID,
    KEY_REQ
  } key_state_e;

  // Decision from the lookup stage
  typedef enum logic [1:0] {
    OP_NONE,
    OP_HIT,
    OP_MISS_FILL,
    OP_BYPASS
  } lookup_op_e;

endpackage

`default_nettype wire

/* icache_tb.sv */
/*
 * Instruction cache testbench
 * Directed fetch tests against a bus memory model and a key provider
 */
`timescale 1ns/100ps
`default_nettype none

module icache_tb import icache_pkg::*; ();

  localparam int CLK_PERIOD  = 4;
  localparam int NUM_TESTS   = 6;
  localparam int TEST_CYCLES = 200;
  localparam int FETCH_LIMIT = 100;

  localparam logic [WORD_W-1:0] WORD_SEED = 32'h9e37_79b9;

  // Test addresses, lines at index 3, 5, 6 and 7
  localparam logic [ADDR_W-1:0] LINE_A   = 32'h0000_1230;
  localparam logic [ADDR_W-1:0] CONF_X   = 32'h0000_2250;
  localparam logic [ADDR_W-1:0] CONF_Y   = 32'h0000_3350;
  localparam logic [ADDR_W-1:0] BYP_LINE = 32'h0000_4460;
  localparam logic [ADDR_W-1:0] ERR_LINE = 32'h0000_5570;

  logic                   clk;
  logic                   rst_n;
  logic                   req_i;
  logic [ADDR_W-1:0]      addr_i;
  logic                   valid_o;
  logic [WORD_W-1:0]      rdata_o;
  logic [ADDR_W-1:0]      addr_o;
  logic                   err_o;
  logic                   icache_enable_i;
  logic                   icache_inval_i;
  logic                   busy_o;
  logic                   instr_req_o;
  logic [ADDR_W-1:0]      instr_addr_o;
  logic                   instr_gnt_i;
  logic                   instr_rvalid_i;
  logic [WORD_W-1:0]      instr_rdata_i;
  logic                   instr_err_i;
  logic                   key_req_o;
  logic                   key_valid_i;
  logic [SCR_KEY_W-1:0]   key_i;
  logic [SCR_NONCE_W-1:0] nonce_i;

  // Memory and key provider state
  logic [31:0]       lcg_state = 32'd10995;
  logic              resp_pend = 1'b0;
  int                resp_wait = 0;
  int                gnt_wait  = 0;
  logic [ADDR_W-1:0] resp_addr = '0;
  logic              err_armed = 1'b0;
  logic [ADDR_W-1:0] err_lo    = '0;
  logic [ADDR_W-1:0] err_hi    = '0;
  logic              key_pend  = 1'b0;
  int                key_wait  = 0;
  int                mem_reqs   = 0;
  int                keys_given = 0;
  int                checks     = 0;
  int                errors     = 0;
  string             cur_test   = "reset";

  icache_top icache_top_inst (
    .clk, .rst_n, .req_i, .addr_i, .valid_o, .rdata_o, .addr_o, .err_o,
    .icache_enable_i, .icache_inval_i, .busy_o,
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_err_i,
    .key_req_o, .key_valid_i, .key_i, .nonce_i
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  function automatic logic [31:0] next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state ^ (lcg_state >> 15);
  endfunction

  // Memory content: address XOR a constant rotated by the word address
  function automatic logic [WORD_W-1:0] model_word(input logic [ADDR_W-1:0] addr);
    logic [2*WORD_W-1:0] dbl;
    dbl = {WORD_SEED, WORD_SEED} << addr[6:2];
    return {addr[ADDR_W-1:2], 2'b00} ^ dbl[2*WORD_W-1:WORD_W];
  endfunction

  // One grant per request, one rvalid per grant, random delays of 0 to 3 cycles
  task automatic serve_memory();
    instr_gnt_i    = 1'b0;
    instr_rvalid_i = 1'b0;
    instr_err_i    = 1'b0;
    if (resp_pend) begin
      if (resp_wait == 0) begin
        instr_rvalid_i = 1'b1;
        instr_rdata_i  = model_word(resp_addr);
        instr_err_i    = err_armed && (resp_addr >= err_lo) && (resp_addr <= err_hi);
        resp_pend      = 1'b0;
      end else begin
        resp_wait = resp_wait - 1;
      end
    end else if (instr_req_o) begin
      if (gnt_wait == 0) begin
        instr_gnt_i = 1'b1;
        resp_addr   = instr_addr_o;
        resp_pend   = 1'b1;
        resp_wait   = next_rand() % 4;
        gnt_wait    = next_rand() % 4;
        mem_reqs++;
      end else begin
        gnt_wait = gnt_wait - 1;
      end
    end
  endtask

  // Valid is held until the request drops
  task automatic serve_key();
    if (key_valid_i) begin
      if (!key_req_o) key_valid_i = 1'b0;
    end else if (key_pend) begin
      if (key_wait == 0) begin
        key_i       = {next_rand(), next_rand()};
        nonce_i     = next_rand();
        key_valid_i = 1'b1;
        key_pend    = 1'b0;
        keys_given++;
      end else begin
        key_wait = key_wait - 1;
      end
    end else if (key_req_o) begin
      key_pend = 1'b1;
      key_wait = next_rand() % 4;
    end
  endtask

  always @(negedge clk) begin
    serve_memory();
    serve_key();
  end

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("Mismatch in %s, %s: expected %h, actual %h", cur_test, what, expected, actual);
    end
  endtask

  // Called on a falling edge, returns on the falling edge that shows valid_o
  task automatic fetch_word(input logic [ADDR_W-1:0] addr, output logic [WORD_W-1:0] data,
                            output logic err, output int lat);
    int n;
    n   = 0;
    lat = 0;
    while (busy_o && n < FETCH_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (busy_o) begin
      errors++;
      $display("Error in %s: cache stayed busy, fetch of %h never issued", cur_test, addr);
    end else begin
      req_i  = 1'b1;
      addr_i = addr;
      do begin
        @(negedge clk);
        req_i = 1'b0;
        lat++;
      end while (!valid_o && lat < FETCH_LIMIT);
      if (!valid_o) begin
        errors++;
        $display("Error in %s: no response to fetch of %h within %0d cycles",
                 cur_test, addr, FETCH_LIMIT);
      end
      check_value("response address", addr, addr_o);
    end
    data = rdata_o;
    err  = err_o;
  endtask

  task automatic fetch_expect(input logic [ADDR_W-1:0] addr, input int exp_reqs,
                              input logic exp_err, output int lat);
    logic [WORD_W-1:0] data;
    logic              err;
    int                base;
    base = mem_reqs;
    fetch_word(addr, data, err, lat);
    check_value("data", model_word(addr), data);
    check_value("memory requests", exp_reqs, mem_reqs - base);
    check_value("error flag", exp_err, err);
  endtask

  task automatic first_miss();
    int lat;
    cur_test = "first_miss";
    fetch_expect(LINE_A + 4, 4, 1'b0, lat);
  endtask

  task automatic line_hits();
    int lat;
    cur_test = "line_hits";
    for (int b = 0; b < 4; b++) begin
      if (b != 1) begin
        fetch_expect(LINE_A + 4 * b, 0, 1'b0, lat);
        check_value("hit latency", 2, lat);
      end
    end
  endtask

  task automatic index_conflict();
    int lat;
    cur_test = "index_conflict";
    for (int i = 0; i < 4; i++) begin
      fetch_expect(((i % 2) ? CONF_Y : CONF_X) + 4 * i, 4, 1'b0, lat);
    end
  endtask

  task automatic bypass_fetches();
    int lat;
    cur_test = "bypass_fetches";
    icache_enable_i = 1'b0;
    fetch_expect(BYP_LINE, 1, 1'b0, lat);
    fetch_expect(BYP_LINE + 8, 1, 1'b0, lat);
    icache_enable_i = 1'b1;
    fetch_expect(BYP_LINE + 4, 4, 1'b0, lat);
  endtask

  task automatic bus_error();
    int lat;
    cur_test  = "bus_error";
    err_lo    = ERR_LINE + 8;
    err_hi    = ERR_LINE + 8;
    err_armed = 1'b1;
    fetch_expect(ERR_LINE, 4, 1'b1, lat);
    err_armed = 1'b0;
    fetch_expect(ERR_LINE, 4, 1'b0, lat);
    fetch_expect(ERR_LINE + 12, 0, 1'b0, lat);
  endtask

  task automatic invalidate_rekey();
    int lat;
    int n;
    int keys_before;
    cur_test    = "invalidate_rekey";
    keys_before = keys_given;
    icache_inval_i = 1'b1;
    @(negedge clk);
    icache_inval_i = 1'b0;
    check_value("key request", 1, key_req_o);
    check_value("busy", 1, busy_o);
    n = 0;
    while (key_req_o && n < FETCH_LIMIT) begin
      @(negedge clk);
      n++;
    end
    if (key_req_o) begin
      errors++;
      $display("Error in %s: key request still pending after %0d cycles", cur_test, n);
    end
    check_value("keys delivered", 1, keys_given - keys_before);
    // Lines cached under the old key must refill
    fetch_expect(LINE_A + 8, 4, 1'b0, lat);
    fetch_expect(CONF_Y, 4, 1'b0, lat);
    fetch_expect(LINE_A, 0, 1'b0, lat);
  endtask

  initial begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    req_i           = 1'b0;
    addr_i          = '0;
    icache_enable_i = 1'b1;
    icache_inval_i  = 1'b0;
    instr_gnt_i     = 1'b0;
    instr_rvalid_i  = 1'b0;
    instr_rdata_i   = '0;
    instr_err_i     = 1'b0;
    key_valid_i     = 1'b0;
    key_i           = '0;
    nonce_i         = '0;
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    check_value("busy after reset", 0, busy_o);
    check_value("key request after reset", 0, key_req_o);
    first_miss();
    line_hits();
    index_conflict();
    bypass_fetches();
    bus_error();
    invalidate_rekey();
    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

  // Watchdog
  initial begin
    #(NUM_TESTS * TEST_CYCLES * CLK_PERIOD);
    $display("Error: run did not finish in time, checks run: %0d, errors: %0d",
             checks, errors);
    $display("CHECKS FAILED");
    $finish;
  end

endmodule

`default_nettype wire

/* icache_top.sv */
/*
 * Scrambled direct-mapped instruction cache
 * Key controller, tag and data RAMs, and the lookup, fill and response stages
 */
`timescale 1ns/100ps
`default_nettype none

module icache_top import icache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  // Core side
  input  logic                   req_i,
  input  logic [ADDR_W-1:0]      addr_i,
  output logic                   valid_o,
  output logic [WORD_W-1:0]      rdata_o,
  output logic [ADDR_W-1:0]      addr_o,
  output logic                   err_o,
  input  logic                   icache_enable_i,
  input  logic                   icache_inval_i,
  output logic                   busy_o,
  // Instruction memory bus
  output logic                   instr_req_o,
  output logic [ADDR_W-1:0]      instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [WORD_W-1:0]      instr_rdata_i,
  input  logic                   instr_err_i,
  // Key provider
  output logic                   key_req_o,
  input  logic                   key_valid_i,
  input  logic [SCR_KEY_W-1:0]   key_i,
  input  logic [SCR_NONCE_W-1:0] nonce_i
);

  logic [SCR_KEY_W-1:0]   scr_key;
  logic [SCR_NONCE_W-1:0] scr_nonce;
  logic                   key_ok;
  logic                   tag_req, data_req, tag_write, data_write;
  logic [IC_INDEX_W-1:0]  wr_index, tag_index, data_index;
  logic [IC_TAG_SIZE-1:0] tag_wdata, tag_rdata;
  logic [IC_LINE_W-1:0]   data_wdata, data_rdata, lookup_line;
  lookup_op_e             lookup_op;
  logic [ADDR_W-1:0]      lookup_addr;
  logic                   fill_busy, fill_line_valid, fill_done, fill_err;
  logic [WORD_W-1:0]      fill_rdata;

  scr_key_ctrl scr_key_ctrl_inst (
    .clk, .rst_n, .inval_i(icache_inval_i), .key_valid_i, .key_i, .nonce_i,
    .key_req_o, .scr_key_o(scr_key), .scr_nonce_o(scr_nonce), .key_ok_o(key_ok)
  );

  // Fill writes take the RAM port, reads index straight from the fetch address
  assign tag_index  = tag_write ? wr_index : addr_i[IC_TAG_LSB-1:IC_INDEX_LSB];
  assign data_index = data_write ? wr_index : addr_i[IC_TAG_LSB-1:IC_INDEX_LSB];

  scr_ram_1p #(.Width(IC_TAG_SIZE)) tag_ram_inst (
    .clk, .rst_n, .req_i(tag_req | tag_write), .write_i(tag_write), .addr_i(tag_index),
    .wdata_i(tag_wdata), .rdata_o(tag_rdata), .key_i(scr_key), .nonce_i(scr_nonce)
  );

  scr_ram_1p #(.Width(IC_LINE_W)) data_ram_inst (
    .clk, .rst_n, .req_i(data_req | data_write), .write_i(data_write), .addr_i(data_index),
    .wdata_i(data_wdata), .rdata_o(data_rdata), .key_i(scr_key), .nonce_i(scr_nonce)
  );

  icache_lookup icache_lookup_inst (
    .clk, .rst_n, .req_i, .addr_i, .enable_i(icache_enable_i), .inval_i(icache_inval_i),
    .key_ok_i(key_ok), .fill_busy_i(fill_busy), .fill_line_valid_i(fill_line_valid),
    .fill_index_i(wr_index), .tag_req_o(tag_req), .tag_rdata_i(tag_rdata),
    .data_req_o(data_req), .data_rdata_i(data_rdata), .lookup_op_o(lookup_op),
    .lookup_addr_o(lookup_addr), .lookup_line_o(lookup_line), .busy_o
  );

  icache_fill icache_fill_inst (
    .clk, .rst_n, .lookup_op_i(lookup_op), .lookup_addr_i(lookup_addr),
    .instr_req_o, .instr_addr_o, .instr_gnt_i, .instr_rvalid_i, .instr_rdata_i, .instr_err_i,
    .tag_write_o(tag_write), .data_write_o(data_write), .wr_index_o(wr_index),
    .tag_wdata_o(tag_wdata), .data_wdata_o(data_wdata), .fill_line_valid_o(fill_line_valid),
    .fill_busy_o(fill_busy), .fill_done_o(fill_done), .fill_rdata_o(fill_rdata),
    .fill_err_o(fill_err)
  );

  icache_output icache_output_inst (
    .clk, .rst_n, .lookup_op_i(lookup_op), .lookup_addr_i(lookup_addr),
    .lookup_line_i(lookup_line), .fill_done_i(fill_done), .fill_rdata_i(fill_rdata),
    .fill_err_i(fill_err), .valid_o, .rdata_o, .addr_o, .err_o
  );

endmodule

`default_nettype wire

/* scr_key_ctrl.sv */
/*
 * Scrambling key controller
 * Keeps key and nonce, drops them on invalidate and requests fresh ones
 */
`timescale 1ns/100ps
`default_nettype none

module scr_key_ctrl import icache_pkg::*; (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inval_i,
  input  logic                   key_valid_i,
  input  logic [SCR_KEY_W-1:0]   key_i,
  input  logic [SCR_NONCE_W-1:0] nonce_i,
  output logic                   key_req_o,
  output logic [SCR_KEY_W-1:0]   scr_key_o,
  output logic [SCR_NONCE_W-1:0] scr_nonce_o,
  output logic                   key_ok_o
);

  key_state_e             state_q, state_d;
  logic [SCR_KEY_W-1:0]   key_q;
  logic [SCR_NONCE_W-1:0] nonce_q;

  always_comb begin
    state_d = state_q;
    unique case (state_q)
      KEY_VALID:   state_d = KEY_VALID;
      // Let a valid still held from the last exchange drop first
      KEY_INVALID: if (!key_valid_i) state_d = KEY_REQ;
      KEY_REQ:     if (key_valid_i) state_d = KEY_VALID;
      default:     state_d = KEY_INVALID;
    endcase
    if (inval_i) begin
      state_d = KEY_INVALID;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= KEY_VALID;
      key_q   <= SCR_RST_KEY;
      nonce_q <= SCR_RST_NONCE;
    end else begin
      state_q <= state_d;
      if (state_q == KEY_REQ && key_valid_i && !inval_i) begin
        key_q   <= key_i;
        nonce_q <= nonce_i;
      end
    end
  end

  assign key_req_o   = (state_q != KEY_VALID);
  assign key_ok_o    = (state_q == KEY_VALID);
  assign scr_key_o   = key_q;
  assign scr_nonce_o = nonce_q;

  // A new request only ever follows an invalidate
  key_req_rise_a: assert property (@(posedge clk) disable iff (!rst_n)
    $rose(key_req_o) |-> $past(inval_i));

endmodule

`default_nettype wire

/* scr_ram_1p.sv */
/*
 * Scrambled single-port RAM
 * Rows are stored XORed with a keystream derived from key, nonce and row index
 */
`timescale 1ns/100ps
`default_nettype none

module scr_ram_1p import icache_pkg::*; #(
  parameter int unsigned Width = 32
) (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   req_i,
  input  logic                   write_i,
  input  logic [IC_INDEX_W-1:0]  addr_i,
  input  logic [Width-1:0]       wdata_i,
  output logic [Width-1:0]       rdata_o,
  input  logic [SCR_KEY_W-1:0]   key_i,
  input  logic [SCR_NONCE_W-1:0] nonce_i
);

  logic [Width-1:0] mem [IC_NUM_LINES];
  logic [Width-1:0] rdata_q;

  // Low key half XOR nonce, rotated by row, upper key half on odd 32-bit replicas
  function automatic logic [Width-1:0] keystream(input logic [IC_INDEX_W-1:0]  row,
                                                 input logic [SCR_KEY_W-1:0]   key,
                                                 input logic [SCR_NONCE_W-1:0] nonce);
    logic [SCR_NONCE_W-1:0]   base;
    logic [2*SCR_NONCE_W-1:0] dbl;
    logic [Width-1:0]         ks;
    base = key[SCR_NONCE_W-1:0] ^ nonce;
    dbl  = {base, base} << row;
    base = dbl[2*SCR_NONCE_W-1:SCR_NONCE_W];
    for (int i = 0; i < Width; i++) begin
      ks[i] = base[i % 32];
      if (((i / 32) % 2) == 1) begin
        ks[i] = ks[i] ^ key[32 + (i % 32)];
      end
    end
    return ks;
  endfunction

  always_ff @(posedge clk) begin
    if (req_i && write_i) begin
      mem[addr_i] <= wdata_i ^ keystream(addr_i, key_i, nonce_i);
    end else if (req_i) begin
      rdata_q <= mem[addr_i] ^ keystream(addr_i, key_i, nonce_i);
    end
  end

  assign rdata_o = rdata_q;

  // Row index must be known whenever the RAM is accessed
  addr_known_a: assert property (@(posedge clk) disable iff (!rst_n)
    req_i |-> !$isunknown(addr_i));

endmodule

`default_nettype wire
